// ==== asconPkg.sv ====
`default_nettype none

package asconPkg;

    // Lane, block and length types
    typedef logic [63:0]  wordT;
    typedef logic [127:0] keyT;
    typedef logic [3:0]   lenT;
    typedef logic [3:0]   roundT;

    // Round schedule, must divide ROUNDS_B
    localparam int ROUNDS_PER_CYCLE = 3;
    localparam int ROUNDS_A         = 12;
    localparam int ROUNDS_B         = 6;
    localparam int BLOCK_BYTES      = 8;

    // ASCON-128 initial value for lane 0
    localparam wordT ASCON_IV = 64'h80400c0600000000;

    typedef enum logic [2:0] {
        opHold,
        opLoad,
        opAbsorb,
        opFinalize,
        opPermute
    } updateOpT;

    typedef enum logic [2:0] {
        stIdle,
        stInit,
        stWaitBlock,
        stBlockPerm,
        stFinalPerm
    } ctrlStateT;

endpackage

`default_nettype wire

// ==== asconPad.sv ====
`timescale 1ns/1ps
`default_nettype none

module asconPad import asconPkg::*; (
    input  wire wordT block,
    input  wire lenT  len,
    output wordT      padded
);

    // Byte 0 sits in the top bits of the block
    always_comb begin
        padded = '0;
        for (int i = 0; i < BLOCK_BYTES; i++) begin
            if (lenT'(i) < len) begin
                padded[(BLOCK_BYTES - 1 - i) * 8 +: 8] = block[(BLOCK_BYTES - 1 - i) * 8 +: 8];
            end else if (lenT'(i) == len) begin
                // First byte past the data carries the pad marker
                padded[(BLOCK_BYTES - 1 - i) * 8 +: 8] = 8'h80;
            end
        end
    end

endmodule

`default_nettype wire

// ==== asconRound.sv ====
`timescale 1ns/1ps
`default_nettype none

module asconRound import asconPkg::*; (
    input  wire roundT round,
    input  wire wordT  x0In,
    input  wire wordT  x1In,
    input  wire wordT  x2In,
    input  wire wordT  x3In,
    input  wire wordT  x4In,
    output wordT       x0Out,
    output wordT       x1Out,
    output wordT       x2Out,
    output wordT       x3Out,
    output wordT       x4Out
);

    logic [7:0] rc;

    function automatic wordT ror(input wordT x, input int unsigned n);
        return (x >> n) | (x << ($bits(wordT) - n));
    endfunction

    // Constant of the 12-round schedule, high nibble counts down
    assign rc = {4'hF - round, round};

    always_comb begin
        wordT a0, a1, a2, a3, a4;
        wordT t0, t1, t2, t3, t4;

        //////////////////////////////////////////////////
        // Constant addition and substitution layer
        a0 = x0In ^ x4In;
        a1 = x1In;
        a2 = x2In ^ {56'd0, rc} ^ x1In;
        a3 = x3In;
        a4 = x4In ^ x3In;

        t0 = ~a0 & a1;
        t1 = ~a1 & a2;
        t2 = ~a2 & a3;
        t3 = ~a3 & a4;
        t4 = ~a4 & a0;

        a0 = a0 ^ t1;
        a1 = a1 ^ t2;
        a2 = a2 ^ t3;
        a3 = a3 ^ t4;
        a4 = a4 ^ t0;

        a1 = a1 ^ a0;
        a0 = a0 ^ a4;
        a3 = a3 ^ a2;
        a2 = ~a2;

        //////////////////////////////////////////////////
        // Linear diffusion, one pair of rotations per lane
        x0Out = a0 ^ ror(a0, 19) ^ ror(a0, 28);
        x1Out = a1 ^ ror(a1, 61) ^ ror(a1, 39);
        x2Out = a2 ^ ror(a2, 1) ^ ror(a2, 6);
        x3Out = a3 ^ ror(a3, 10) ^ ror(a3, 17);
        x4Out = a4 ^ ror(a4, 7) ^ ror(a4, 41);
    end

endmodule

`default_nettype wire

// ==== asconStateUpdate.sv ====
`timescale 1ns/1ps
`default_nettype none

module asconStateUpdate import asconPkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire updateOpT updateOp,
    input  wire           firstBlock,
    input  wire keyT      key,
    input  wire keyT      nonce,
    input  wire wordT     ptBlock,
    input  wire lenT      ptLen,
    output wordT          f0,
    output wordT          f1,
    output wordT          f2,
    output wordT          f3,
    output wordT          f4,
    input  wire wordT     r0,
    input  wire wordT     r1,
    input  wire wordT     r2,
    input  wire wordT     r3,
    input  wire wordT     r4,
    output keyT           keyHeld
);

    wordT s0, s1, s2, s3, s4;
    wordT padded;

    asconPad uPad (
        .block (ptBlock),
        .len   (ptLen),
        .padded(padded)
    );

    //////////////////////////////////////////////////
    // Feed into the round chain
    always_comb begin
        f0 = s0;
        f1 = s1;
        f2 = s2;
        f3 = s3;
        f4 = s4;
        case (updateOp)
            opLoad: begin
                f0 = ASCON_IV;
                f1 = key[127:64];
                f2 = key[63:0];
                f3 = nonce[127:64];
                f4 = nonce[63:0];
            end
            opAbsorb, opFinalize: begin
                f0 = s0 ^ padded;
                // Key XOR closing init, then the domain bit
                if (firstBlock) begin
                    f3 = s3 ^ keyHeld[127:64];
                    f4 = s4 ^ keyHeld[63:0] ^ 64'd1;
                end
                if (updateOp == opFinalize) begin
                    f1 = s1 ^ keyHeld[127:64];
                    f2 = s2 ^ keyHeld[63:0];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s0 <= '0;
            s1 <= '0;
            s2 <= '0;
            s3 <= '0;
            s4 <= '0;
        end else if (updateOp != opHold) begin
            s0 <= r0;
            s1 <= r1;
            s2 <= r2;
            s3 <= r3;
            s4 <= r4;
        end
    end

    always_ff @(posedge clk) begin
        if (updateOp == opLoad) begin
            keyHeld <= key;
        end
    end

endmodule

`default_nettype wire

// ==== asconControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module asconControl import asconPkg::*; (
    input  wire clk,
    input  wire rst,
    input  wire start,
    input  wire ptValid,
    input  wire ptLast,
    output updateOpT updateOp,
    output roundT    roundBase,
    output logic     firstBlock,
    output logic     captureCt,
    output logic     captureTag,
    output logic     ptReady,
    output logic     busy
);

    ctrlStateT state, nextState;
    roundT     roundCnt;
    logic      lastGroup;

    // Blocks run the tail of the schedule, init and final run all of it
    always_comb begin
        case (state)
            stIdle:      roundBase = '0;
            stWaitBlock: roundBase = ptLast ? '0 : roundT'(ROUNDS_A - ROUNDS_B);
            default:     roundBase = roundCnt;
        endcase
    end

    assign lastGroup = (roundBase == roundT'(ROUNDS_A - ROUNDS_PER_CYCLE));

    always_comb begin
        nextState  = state;
        updateOp   = opHold;
        captureCt  = 1'b0;
        captureTag = 1'b0;
        case (state)
            stIdle: begin
                if (start) begin
                    updateOp  = opLoad;
                    nextState = stInit;
                end
            end
            stWaitBlock: begin
                if (ptValid) begin
                    captureCt = 1'b1;
                    if (ptLast) begin
                        updateOp  = opFinalize;
                        nextState = stFinalPerm;
                    end else begin
                        updateOp  = opAbsorb;
                        nextState = lastGroup ? stWaitBlock : stBlockPerm;
                    end
                end
            end
            stInit, stBlockPerm: begin
                updateOp = opPermute;
                if (lastGroup) nextState = stWaitBlock;
            end
            stFinalPerm: begin
                updateOp = opPermute;
                if (lastGroup) begin
                    captureTag = 1'b1;
                    nextState  = stIdle;
                end
            end
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= stIdle;
            roundCnt   <= '0;
            firstBlock <= 1'b0;
        end else begin
            state <= nextState;
            if (updateOp != opHold) roundCnt <= roundBase + roundT'(ROUNDS_PER_CYCLE);
            // Key XOR of init is still owed until the first block
            if (updateOp == opLoad) begin
                firstBlock <= 1'b1;
            end else if (captureCt) begin
                firstBlock <= 1'b0;
            end
        end
    end

    assign ptReady = (state == stWaitBlock);
    assign busy    = (state != stIdle);

endmodule

`default_nettype wire

// ==== asconOutput.sv ====
`timescale 1ns/1ps
`default_nettype none

module asconOutput import asconPkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       captureCt,
    input  wire       captureTag,
    input  wire wordT absorbed,
    input  wire lenT  ptLen,
    input  wire wordT t3,
    input  wire wordT t4,
    input  wire keyT  keyHeld,
    output logic      ctValid,
    output wordT      ctBlock,
    output logic      tagValid,
    output keyT       tag
);

    wordT ctMask;

    // Keeps the leading ptLen bytes, a full block keeps all
    assign ctMask = ~({$bits(wordT){1'b1}} >> {ptLen, 3'b000});

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctValid  <= 1'b0;
            tagValid <= 1'b0;
        end else begin
            ctValid  <= captureCt;
            tagValid <= captureTag;
        end
    end

    always_ff @(posedge clk) begin
        if (captureCt) ctBlock <= absorbed & ctMask;
        if (captureTag) tag <= {t3, t4} ^ keyHeld;
    end

endmodule

`default_nettype wire

// ==== asconCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module asconCore import asconPkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       start,
    input  wire keyT  key,
    input  wire keyT  nonce,
    input  wire       ptValid,
    input  wire wordT ptBlock,
    input  wire lenT  ptLen,
    input  wire       ptLast,
    output logic      ptReady,
    output logic      busy,
    output logic      ctValid,
    output wordT      ctBlock,
    output logic      tagValid,
    output keyT       tag
);

    updateOpT updateOp;
    roundT    roundBase;
    logic     firstBlock;
    logic     captureCt;
    logic     captureTag;
    keyT      keyHeld;

    // Five lanes between each pair of rounds
    wire wordT lane [0:ROUNDS_PER_CYCLE][0:4];

    asconControl uControl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .ptValid   (ptValid),
        .ptLast    (ptLast),
        .updateOp  (updateOp),
        .roundBase (roundBase),
        .firstBlock(firstBlock),
        .captureCt (captureCt),
        .captureTag(captureTag),
        .ptReady   (ptReady),
        .busy      (busy)
    );

    asconStateUpdate uStateUpdate (
        .clk       (clk),
        .rst       (rst),
        .updateOp  (updateOp),
        .firstBlock(firstBlock),
        .key       (key),
        .nonce     (nonce),
        .ptBlock   (ptBlock),
        .ptLen     (ptLen),
        .f0        (lane[0][0]),
        .f1        (lane[0][1]),
        .f2        (lane[0][2]),
        .f3        (lane[0][3]),
        .f4        (lane[0][4]),
        .r0        (lane[ROUNDS_PER_CYCLE][0]),
        .r1        (lane[ROUNDS_PER_CYCLE][1]),
        .r2        (lane[ROUNDS_PER_CYCLE][2]),
        .r3        (lane[ROUNDS_PER_CYCLE][3]),
        .r4        (lane[ROUNDS_PER_CYCLE][4]),
        .keyHeld   (keyHeld)
    );

    //////////////////////////////////////////////////
    // Unrolled rounds, one group per clock
    for (genvar g = 0; g < ROUNDS_PER_CYCLE; g++) begin : gRound
        asconRound uRound (
            .round(roundBase + roundT'(g)),
            .x0In (lane[g][0]),
            .x1In (lane[g][1]),
            .x2In (lane[g][2]),
            .x3In (lane[g][3]),
            .x4In (lane[g][4]),
            .x0Out(lane[g + 1][0]),
            .x1Out(lane[g + 1][1]),
            .x2Out(lane[g + 1][2]),
            .x3Out(lane[g + 1][3]),
            .x4Out(lane[g + 1][4])
        );
    end

    asconOutput uOutput (
        .clk       (clk),
        .rst       (rst),
        .captureCt (captureCt),
        .captureTag(captureTag),
        .absorbed  (lane[0][0]),
        .ptLen     (ptLen),
        .t3        (lane[ROUNDS_PER_CYCLE][3]),
        .t4        (lane[ROUNDS_PER_CYCLE][4]),
        .keyHeld   (keyHeld),
        .ctValid   (ctValid),
        .ctBlock   (ctBlock),
        .tagValid  (tagValid),
        .tag       (tag)
    );

endmodule

`default_nettype wire

// ==== asconCoreProps.sv ====
`timescale 1ns/1ps
`default_nettype none

module asconCoreProps import asconPkg::*; (
    input wire      clk,
    input wire      rst,
    input wire      ptValid,
    input wire      ptReady,
    input wire      ptLast,
    input wire lenT ptLen,
    input wire      ctValid,
    input wire      tagValid
);

    // Failed properties so far
    int unsigned failCount = 0;
    logic accepted;

    assign accepted = ptValid && ptReady;

    ctAfterAccept: assert property (@(posedge clk) disable iff (rst) accepted |=> ctValid)
        else begin
            $error("ctValid did not follow an accepted block by one cycle");
            failCount++;
        end

    ctOnlyAfterAccept: assert property (@(posedge clk) disable iff (rst)
        ctValid |-> $past(accepted))
        else begin
            $error("ctValid pulsed without an accepted block");
            failCount++;
        end

    tagAfterLast: assert property (@(posedge clk) disable iff (rst)
        $past(accepted && ptLast, 4) |-> tagValid)
        else begin
            $error("tagValid missing four cycles after the last block");
            failCount++;
        end

    // Last block is always short
    lastShort: assert property (@(posedge clk) disable iff (rst)
        accepted && ptLast |-> ptLen < lenT'(BLOCK_BYTES))
        else begin
            $error("Last block accepted with a full length");
            failCount++;
        end

endmodule

bind asconCore asconCoreProps uProps (
    .clk     (clk),
    .rst     (rst),
    .ptValid (ptValid),
    .ptReady (ptReady),
    .ptLast  (ptLast),
    .ptLen   (ptLen),
    .ctValid (ctValid),
    .tagValid(tagValid)
);

`default_nettype wire

// ==== asconCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module asconCoreTb import asconPkg::*; ();

    localparam int NUM_MSGS   = 8;
    localparam int MSG_CYCLES = 40;
    localparam int CLK_PERIOD = 8;
    // ASCON S-box, entry 0 in the low bits
    localparam logic [159:0] SBOX = {
        5'h17, 5'h0f, 5'h0a, 5'h16, 5'h19, 5'h01, 5'h0c, 5'h10,
        5'h18, 5'h11, 5'h0d, 5'h00, 5'h0e, 5'h07, 5'h13, 5'h1e,
        5'h1c, 5'h06, 5'h03, 5'h1d, 5'h12, 5'h08, 5'h05, 5'h1b,
        5'h02, 5'h09, 5'h15, 5'h1a, 5'h14, 5'h1f, 5'h0b, 5'h04
    };

    logic clk;
    logic rst;
    logic start;
    keyT  key;
    keyT  nonce;
    logic ptValid;
    wordT ptBlock;
    lenT  ptLen;
    logic ptLast;
    logic ptReady;
    logic busy;
    logic ctValid;
    wordT ctBlock;
    logic tagValid;
    keyT  tag;

    wordT msgBlocks [4];
    wordT expCt [4];

    asconCore u_dut (
        .clk(clk), .rst(rst), .start(start), .key(key), .nonce(nonce),
        .ptValid(ptValid), .ptBlock(ptBlock), .ptLen(ptLen), .ptLast(ptLast),
        .ptReady(ptReady), .busy(busy), .ctValid(ctValid), .ctBlock(ctBlock),
        .tagValid(tagValid), .tag(tag)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Reference model of ASCON-128 encryption
    function automatic wordT ror(input wordT v, input int n);
        return wordT'({v, v} >> n);
    endfunction

    // Last `rounds` rounds of the 12-round schedule
    function automatic logic [319:0] permute(input logic [319:0] s, input int rounds);
        wordT       x [5];
        logic [4:0] col;
        logic [4:0] sub;
        for (int i = 0; i < 5; i++) x[i] = s[319 - 64 * i -: 64];
        for (int r = 12 - rounds; r < 12; r++) begin
            x[2] = x[2] ^ wordT'(8'hf0 - 8'(15 * r));
            for (int b = 0; b < 64; b++) begin
                col = {x[0][b], x[1][b], x[2][b], x[3][b], x[4][b]};
                sub = SBOX[5 * col +: 5];
                x[0][b] = sub[4];
                x[1][b] = sub[3];
                x[2][b] = sub[2];
                x[3][b] = sub[1];
                x[4][b] = sub[0];
            end
            x[0] = x[0] ^ ror(x[0], 19) ^ ror(x[0], 28);
            x[1] = x[1] ^ ror(x[1], 61) ^ ror(x[1], 39);
            x[2] = x[2] ^ ror(x[2], 1) ^ ror(x[2], 6);
            x[3] = x[3] ^ ror(x[3], 10) ^ ror(x[3], 17);
            x[4] = x[4] ^ ror(x[4], 7) ^ ror(x[4], 41);
        end
        return {x[0], x[1], x[2], x[3], x[4]};
    endfunction

    // Fills expCt from msgBlocks and returns the tag
    function automatic keyT encryptRef(input keyT k, input keyT n, input int nBlocks,
                                       input int lastLen);
        logic [319:0] s;
        wordT         keep;
        wordT         p;
        int           len;
        s = permute({64'h80400c0600000000, k, n}, 12);
        s[127:0] = s[127:0] ^ k;
        s[0] = s[0] ^ 1'b1;
        for (int i = 0; i < nBlocks; i++) begin
            len = (i == nBlocks - 1) ? lastLen : 8;
            keep = (len == 0) ? '0 : ~64'd0 << (64 - 8 * len);
            p = msgBlocks[i] & keep;
            if (len < 8) p = p | (64'h80 << (56 - 8 * len));
            s[319:256] = s[319:256] ^ p;
            expCt[i] = s[319:256] & keep;
            if (i < nBlocks - 1) s = permute(s, 6);
        end
        s[255:128] = s[255:128] ^ k;
        s = permute(s, 12);
        return s[127:0] ^ k;
    endfunction

    //////////////////////////////////////////////////
    task automatic reportFailure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
        assert (actual === expected) else reportFailure($sformatf(
            "Error: %s expected %0h actual %0h", name, expected, actual));
    endtask

    task automatic startMessage(input keyT k, input keyT n, input bit stray,
                                input string name);
        int cycles;
        @(posedge clk);
        start <= 1'b1;
        key   <= k;
        nonce <= n;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            // Second start and a block during init, both ignored
            start   <= stray && (cycles == 1);
            ptValid <= stray && (cycles == 1);
            if (stray) begin
                key   <= ~k;
                nonce <= ~n;
            end
            @(negedge clk);
            if (cycles == 1) checkValue({name, " busy"}, 1, busy);
        end while (!ptReady && cycles < 8);
        checkValue({name, " ready latency"}, 4, cycles);
    endtask

    task automatic sendBlock(input wordT blk, input lenT len, input bit last,
                             input bit stray, input wordT expBlock, input keyT expTag,
                             input string name);
        int cycles;
        @(posedge clk);
        ptValid <= 1'b1;
        ptBlock <= blk;
        ptLen   <= len;
        ptLast  <= last;
        @(posedge clk);
        ptValid <= stray;
        ptBlock <= ~blk;
        @(negedge clk);
        checkValue({name, " ctValid"}, 1, ctValid);
        checkValue({name, " ctBlock"}, expBlock, ctBlock);
        checkValue({name, " ptReady busy"}, 0, ptReady);
        cycles = 1;
        if (!last) begin
            @(posedge clk);
            ptValid <= 1'b0;
            @(negedge clk);
            checkValue({name, " ptReady return"}, 1, ptReady);
            checkValue({name, " ctValid pulse"}, 0, ctValid);
        end else begin
            while (!tagValid && cycles < 8) begin
                @(posedge clk);
                ptValid <= 1'b0;
                cycles++;
                @(negedge clk);
            end
            checkValue({name, " tag latency"}, 4, cycles);
            checkValue({name, " tag"}, expTag, tag);
            checkValue({name, " busy"}, 0, busy);
        end
    endtask

    // Bound port properties, polled between clock edges
    always @(negedge clk) begin
        if (u_dut.uProps.failCount != 0) begin
            reportFailure("A port property of the core failed");
        end
    end

    initial begin : watchdog
        #((NUM_MSGS * MSG_CYCLES + 20) * CLK_PERIOD);
        reportFailure("Watchdog expired before all messages finished");
    end

    initial begin : stimulus
        keyT msgKey;
        keyT msgNonce;
        keyT expTag;
        int  nBlocks;
        int  lastLen;
        int  offset;
        void'($urandom(32'hce18));
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        key = '0;
        nonce = '0;
        ptValid = 1'b0;
        ptBlock = '0;
        ptLen = '0;
        ptLast = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("reset", 0, {ctValid, tagValid, ptReady, busy});
        // Every last-block length and block count gets covered
        offset = $urandom_range(7, 0);
        for (int m = 0; m < NUM_MSGS; m++) begin
            msgKey = {$urandom(), $urandom(), $urandom(), $urandom()};
            msgNonce = {$urandom(), $urandom(), $urandom(), $urandom()};
            nBlocks = m % 4 + 1;
            lastLen = (m + offset) % 8;
            for (int b = 0; b < nBlocks; b++) msgBlocks[b] = {$urandom(), $urandom()};
            expTag = encryptRef(msgKey, msgNonce, nBlocks, lastLen);
            startMessage(msgKey, msgNonce, m % 2 == 1, $sformatf("msg%0d start", m));
            for (int b = 0; b < nBlocks; b++) begin
                sendBlock(msgBlocks[b], (b == nBlocks - 1) ? lenT'(lastLen) : lenT'(8),
                          b == nBlocks - 1, m % 2 == 1, expCt[b], expTag,
                          $sformatf("msg%0d blk%0d", m, b));
            end
        end
        repeat (2) @(posedge clk);
        if (u_dut.uProps.failCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d port property failures", u_dut.uProps.failCount);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
asconPkg.sv
asconPad.sv
asconRound.sv
asconStateUpdate.sv
asconControl.sv
asconOutput.sv
asconCore.sv
asconCoreProps.sv
asconCoreTb.sv

// ==== Makefile ====
# Verilator build of the ASCON-128 core testbench

VERILATOR ?= verilator
TOP       ?= asconCoreTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)
